// File: verilog.f
+incdir+source
source/proc_pkg.sv
source/instr_fetch.sv
source/instr_decode.sv
source/execute.sv
source/data_mem.sv
source/proc.sv
testbench/proc_checker.sv
testbench/proc_tb.sv

// File: Bender.yml
package:
  name: proc

sources:
  - include_dirs:
      - source
    files:
      - source/proc_pkg.sv
      - source/instr_fetch.sv
      - source/instr_decode.sv
      - source/execute.sv
      - source/data_mem.sv
      - source/proc.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/proc_checker.sv
      - testbench/proc_tb.sv

// File: testbench/proc_tb.sv
`timescale 1ns/1ps

`include "proc_settings.svh"

module proc_tb;

  import procPkg::*;

  localparam int NumProgs  = 4;
  localparam int MaxWords  = 16;
  localparam int MaxEvents = 12;
  localparam int Timeout   = 200;

  logic     clk;
  logic     rst;
  progLoadT progLoad;
  wbEventT  wbEvent;
  logic     halt;
  logic     err;

  // Stimulus and expected results, one row per program
  logic [15:0] progWords [NumProgs][MaxWords];
  int          progLen   [NumProgs];
  wbEventT     expEvents [NumProgs][MaxEvents];
  int          expCount  [NumProgs];
  logic        expHalt   [NumProgs];
  logic        expErr    [NumProgs];
  logic        sawErr;

  proc dut (
    .clk      (clk),
    .rst      (rst),
    .progLoad (progLoad),
    .wbEvent  (wbEvent),
    .halt     (halt),
    .err      (err)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Instruction encoders
  function automatic logic [15:0] encI(opcodeT op, int rd, int rs, int imm);
    logic [4:0] imm5;
    imm5 = imm[4:0];
    return {op, rs[2:0], rd[2:0], imm5};
  endfunction

  function automatic logic [15:0] encR(aluOpT fn, int rd, int rs, int rt);
    return {opAlu, rs[2:0], rt[2:0], rd[2:0], fn};
  endfunction

  function automatic logic [15:0] encJ(int disp);
    logic [10:0] d;
    d = disp[10:0];
    return {opJ, d};
  endfunction

  task automatic addWord(input int p, input logic [15:0] w);
    progWords[p][progLen[p]] = w;
    progLen[p]++;
  endtask

  task automatic addEvent(input int p, input int r, input logic [15:0] d);
    expEvents[p][expCount[p]].valid  = 1'b1;
    expEvents[p][expCount[p]].regNum = r[2:0];
    expEvents[p][expCount[p]].data   = d;
    expCount[p]++;
  endtask

  task automatic abortRun();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic checkWb(input wbEventT got, input wbEventT exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got r%0d=%h valid %b, expected r%0d=%h",
               $time, what, got.regNum, got.data, got.valid, exp.regNum, exp.data);
      abortRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic fillTable();
    for (int p = 0; p < NumProgs; p++) begin
      progLen[p]  = 0;
      expCount[p] = 0;
    end
    // Program 0 runs R-format and I-format ALU ops with sign-extended immediates
    addWord(0, encI(opAddi, 1, 0, 7));
    addEvent(0, 1, 16'h0007);
    addWord(0, encI(opAddi, 2, 0, -3));
    addEvent(0, 2, 16'hFFFD);
    addWord(0, encR(aluAdd, 3, 1, 2));
    addEvent(0, 3, 16'h0004);
    addWord(0, encR(aluSub, 4, 2, 1));
    addEvent(0, 4, 16'hFFF6);
    addWord(0, encR(aluXor, 5, 1, 2));
    addEvent(0, 5, 16'hFFFA);
    addWord(0, encR(aluAndn, 6, 2, 1));
    addEvent(0, 6, 16'hFFF8);
    addWord(0, encI(opAddi, 7, 0, -1));
    addEvent(0, 7, 16'hFFFF);
    addWord(0, encI(opSubi, 7, 7, -16));
    addEvent(0, 7, 16'h000F);
    addWord(0, encI(opXori, 1, 1, 5));
    addEvent(0, 1, 16'h0002);
    addWord(0, encI(opAndni, 2, 2, 15));
    addEvent(0, 2, 16'hFFF0);
    addWord(0, 16'h0000);
    expHalt[0] = 1'b1;
    expErr[0]  = 1'b0;
    // Program 1 stores and loads back at address 12
    addWord(1, encI(opAddi, 1, 0, 9));
    addEvent(1, 1, 16'h0009);
    addWord(1, encI(opAddi, 2, 0, -7));
    addEvent(1, 2, 16'hFFF9);
    addWord(1, encI(opSt, 2, 1, 3));
    addWord(1, encI(opAddi, 3, 0, 10));
    addEvent(1, 3, 16'h000A);
    addWord(1, encI(opLd, 4, 3, 2));
    addEvent(1, 4, 16'hFFF9);
    addWord(1, encR(aluAdd, 5, 4, 1));
    addEvent(1, 5, 16'h0002);
    addWord(1, 16'h0000);
    expHalt[1] = 1'b1;
    expErr[1]  = 1'b0;
    // Program 2 mixes taken and untaken branches with jumps both ways
    addWord(2, encI(opAddi, 1, 0, 1));
    addEvent(2, 1, 16'h0001);
    addWord(2, encI(opBeqz, 0, 1, 2));
    addWord(2, encI(opAddi, 2, 0, 2));
    addEvent(2, 2, 16'h0002);
    addWord(2, encI(opBnez, 0, 1, 1));
    addWord(2, encI(opAddi, 3, 0, 3));
    addWord(2, encI(opBeqz, 0, 0, 1));
    addWord(2, encI(opAddi, 4, 0, 4));
    addWord(2, encI(opBnez, 0, 0, 2));
    addWord(2, encJ(3));
    addWord(2, encI(opAddi, 5, 0, 5));
    addWord(2, 16'h0000);
    addWord(2, encI(opAddi, 6, 0, 6));
    addWord(2, encI(opAddi, 7, 0, 7));
    addEvent(2, 7, 16'h0007);
    addWord(2, encJ(-5));
    addEvent(2, 5, 16'h0005);
    expHalt[2] = 1'b1;
    expErr[2]  = 1'b0;
    // Program 3 has an undefined opcode in the middle
    addWord(3, encI(opAddi, 1, 0, 4));
    addEvent(3, 1, 16'h0004);
    addWord(3, 16'hF800);
    addWord(3, encI(opAddi, 2, 1, -2));
    addEvent(3, 2, 16'h0002);
    addWord(3, {opNop, 11'd0});
    addWord(3, 16'h0000);
    addWord(3, encI(opAddi, 3, 0, 1));
    expHalt[3] = 1'b1;
    expErr[3]  = 1'b1;
  endtask

  // Reset held at least 8 cycles while words load one per cycle
  task automatic loadProgram(input int p);
    int cycles;
    cycles = (progLen[p] > 8) ? progLen[p] : 8;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      #5;
      rst = 1'b1;
      if (c < progLen[p]) begin
        progLoad.valid = 1'b1;
        progLoad.addr  = c[`PROC_IMEM_AW-1:0];
        progLoad.data  = progWords[p][c];
      end else begin
        progLoad = '0;
      end
    end
    @(posedge clk);
    #5;
    progLoad = '0;
    rst      = 1'b0;
  endtask

  task automatic waitForEvent(input int p, input int n);
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    while (!got) begin
      @(negedge clk);
      cycles++;
      if (err) sawErr = 1'b1;
      if (wbEvent.valid) begin
        got = 1'b1;
      end else if (halt) begin
        $display("Program %0d halted before its write-back event %0d", p, n);
        abortRun();
      end else if (cycles >= Timeout) begin
        $display("Timed out waiting for write-back event %0d of program %0d", n, p);
        abortRun();
      end
    end
  endtask

  task automatic waitForHalt(input int p);
    int cycles;
    cycles = 0;
    while (!halt) begin
      @(negedge clk);
      cycles++;
      if (err) sawErr = 1'b1;
      if (wbEvent.valid) begin
        $display("CHECK FAILED at %0t: unexpected write-back event r%0d=%h in program %0d",
                 $time, wbEvent.regNum, wbEvent.data, p);
        abortRun();
      end
      if (!halt && cycles >= Timeout) begin
        $display("Timed out waiting for halt in program %0d", p);
        abortRun();
      end
    end
  endtask

  initial begin
    rst      = 1'b1;
    progLoad = '0;
    sawErr   = 1'b0;
    fillTable();
    for (int p = 0; p < NumProgs; p++) begin
      loadProgram(p);
      sawErr = 1'b0;
      for (int n = 0; n < expCount[p]; n++) begin
        waitForEvent(p, n);
        checkWb(wbEvent, expEvents[p][n], $sformatf("program %0d event %0d", p, n));
      end
      waitForHalt(p);
      // Halted core must stay quiet
      repeat (10) begin
        @(negedge clk);
        checkFlag("halt", halt, expHalt[p]);
        checkFlag("wbEvent.valid after halt", wbEvent.valid, 1'b0);
      end
      checkFlag($sformatf("err seen in program %0d", p), sawErr, expErr[p]);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: testbench/proc_checker.sv
`timescale 1ns/1ps

module proc_checker (
  input logic             clk,
  input logic             rst,
  input logic             halt,
  input logic             err,
  input procPkg::wbEventT wbEvent
);

  // Once halted, the core stays halted and retires nothing until reset
  property haltSticky;
    @(posedge clk) disable iff (rst)
      halt |=> (halt && !wbEvent.valid);
  endproperty

  // Reset leaves the outputs quiet from its second cycle on
  property resetQuiet;
    @(posedge clk) (rst && $past(rst)) |-> (!halt && !err && !wbEvent.valid);
  endproperty

  // Illegal instructions never write a register
  property errNoWrite;
    @(posedge clk) disable iff (rst)
      !(err && wbEvent.valid);
  endproperty

  assertHaltSticky: assert property (haltSticky)
    else $error("halt dropped or an event followed it");
  assertResetQuiet: assert property (resetQuiet)
    else $error("halt, err or a write-back event while reset is held");
  assertErrNoWrite: assert property (errNoWrite)
    else $error("err and a write-back event in the same cycle");

endmodule

bind proc proc_checker procCheck (
  .clk     (clk),
  .rst     (rst),
  .halt    (halt),
  .err     (err),
  .wbEvent (wbEvent)
);

// File: source/proc.sv
`timescale 1ns/1ps

module proc (
  input  logic              clk,
  input  logic              rst,
  input  procPkg::progLoadT progLoad,
  output procPkg::wbEventT  wbEvent,
  output logic              halt,
  output logic              err
);

  import procPkg::*;

  instrT       instr;
  logic [15:0] pcPlusOne;
  decodedT     decoded;
  execT        exec;
  logic        redirect;
  logic [15:0] target;

  // Fetch, PC and instruction memory
  instr_fetch fetchStage (
    .clk       (clk),
    .rst       (rst),
    .progLoad  (progLoad),
    .redirect  (redirect),
    .target    (target),
    .halted    (decoded.ctrl.halt),
    .instr     (instr),
    .pcPlusOne (pcPlusOne),
    .halt      (halt)
  );

  // Decode and register file
  instr_decode decodeStage (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .pcPlusOne (pcPlusOne),
    .wbEvent   (wbEvent),
    .decoded   (decoded),
    .err       (err)
  );

  execute executeStage (
    .decoded  (decoded),
    .exec     (exec),
    .redirect (redirect),
    .target   (target)
  );

  // Memory access and write-back
  data_mem memStage (
    .clk     (clk),
    .exec    (exec),
    .wbEvent (wbEvent)
  );

endmodule

// File: source/data_mem.sv
`timescale 1ns/1ps

`include "proc_settings.svh"

module data_mem (
  input  logic             clk,
  input  procPkg::execT    exec,
  output procPkg::wbEventT wbEvent
);

  logic [15:0]               dmem [`PROC_DMEM_DEPTH];
  logic [`PROC_DMEM_AW-1:0]  addr;
  logic [15:0]               loadData;

  // Word address from the low ALU bits
  assign addr = exec.aluResult[`PROC_DMEM_AW-1:0];

  always_ff @(posedge clk) begin
    if (exec.ctrl.memWrite) begin
      dmem[addr] <= exec.storeData;
    end
  end

  // Asynchronous read for loads
  assign loadData = exec.ctrl.memRead ? dmem[addr] : 16'd0;

  // Event doubles as the register file write port
  always_comb begin
    wbEvent.valid  = exec.ctrl.regWrite;
    wbEvent.regNum = exec.writeReg;
    wbEvent.data   = exec.ctrl.memToReg ? loadData : exec.aluResult;
  end

endmodule

// File: source/execute.sv
`timescale 1ns/1ps

module execute (
  input  procPkg::decodedT decoded,
  output procPkg::execT    exec,
  output logic             redirect,
  output logic [15:0]      target
);

  import procPkg::*;

  logic        rFormat;
  aluOpT       op;
  logic [15:0] operandB;
  logic [15:0] aluResult;
  logic        rsZero;
  logic        taken;

  // Only R-format writes a register without an immediate operand
  assign rFormat = decoded.ctrl.regWrite && !decoded.ctrl.aluSrc;

  assign op       = rFormat ? aluOpT'(decoded.immediate[1:0]) : decoded.ctrl.aluOp;
  assign operandB = decoded.ctrl.aluSrc ? decoded.immediate : decoded.rtData;

  // Results wrap at 16 bits
  always_comb begin
    case (op)
      aluAdd:  aluResult = decoded.rsData + operandB;
      aluSub:  aluResult = decoded.rsData - operandB;
      aluXor:  aluResult = decoded.rsData ^ operandB;
      aluAndn: aluResult = decoded.rsData & ~operandB;
      default: aluResult = '0;
    endcase
  end

  // BEQZ takes the branch on zero, BNEZ on nonzero
  assign rsZero = (decoded.rsData == 16'd0);
  assign taken  = decoded.ctrl.branch && (rsZero == decoded.ctrl.branchOnZero);

  assign redirect = decoded.ctrl.jump || taken;

  // Immediate holds imm5 for branches and disp11 for J
  assign target = decoded.pcPlusOne + decoded.immediate;

  always_comb begin
    exec.ctrl      = decoded.ctrl;
    exec.aluResult = aluResult;
    exec.storeData = decoded.rtData;
    exec.writeReg  = decoded.writeReg;
  end

endmodule

// File: source/instr_decode.sv
`timescale 1ns/1ps

`include "proc_settings.svh"

module instr_decode (
  input  logic             clk,
  input  logic             rst,
  input  procPkg::instrT   instr,
  input  logic [15:0]      pcPlusOne,
  input  procPkg::wbEventT wbEvent,
  output procPkg::decodedT decoded,
  output logic             err
);

  import procPkg::*;

  logic [15:0] regs [`PROC_NUM_REGS];
  ctrlT        ctrl;

  // Undefined opcodes decode as NOP and raise err
  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = aluAdd;
    err        = 1'b0;
    // Nothing executes while reset is held
    if (!rst) begin
      case (instr.r.opcode)
        opHalt: ctrl.halt = 1'b1;
        opNop: ctrl.aluOp = aluAdd;
        opAddi, opSubi, opXori, opAndni: begin
          ctrl.regWrite = 1'b1;
          ctrl.aluSrc   = 1'b1;
          ctrl.aluOp    = aluOpT'(instr.i.opcode[1:0]);
        end
        // ALU operation comes from funct in execute
        opAlu: ctrl.regWrite = 1'b1;
        opLd: begin
          ctrl.regWrite = 1'b1;
          ctrl.aluSrc   = 1'b1;
          ctrl.memRead  = 1'b1;
          ctrl.memToReg = 1'b1;
        end
        opSt: begin
          ctrl.aluSrc   = 1'b1;
          ctrl.memWrite = 1'b1;
        end
        opBeqz: begin
          ctrl.branch       = 1'b1;
          ctrl.branchOnZero = 1'b1;
        end
        opBnez: ctrl.branch = 1'b1;
        opJ: ctrl.jump = 1'b1;
        default: err = 1'b1;
      endcase
    end
  end

  // Register file written from the write-back event
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `PROC_NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (wbEvent.valid) begin
      regs[wbEvent.regNum] <= wbEvent.data;
    end
  end

  always_comb begin
    decoded.ctrl   = ctrl;
    decoded.rsData = regs[instr.r.rs];
    // Bits [7:5] are rt for R-format and the store source for ST
    decoded.rtData = regs[instr.r.rt];
    // R-format keeps funct in the low immediate bits
    if (instr.j.opcode == opJ) begin
      decoded.immediate = {{5{instr.j.disp11[10]}}, instr.j.disp11};
    end else begin
      decoded.immediate = {{11{instr.i.imm5[4]}}, instr.i.imm5};
    end
    decoded.writeReg  = (instr.r.opcode == opAlu) ? instr.r.rd : instr.i.rd;
    decoded.pcPlusOne = pcPlusOne;
  end

endmodule

// File: source/instr_fetch.sv
`timescale 1ns/1ps

`include "proc_settings.svh"

module instr_fetch (
  input  logic              clk,
  input  logic              rst,
  input  procPkg::progLoadT progLoad,
  input  logic              redirect,
  input  logic [15:0]       target,
  input  logic              halted,
  output procPkg::instrT    instr,
  output logic [15:0]       pcPlusOne,
  output logic              halt
);

  logic [15:0] imem [`PROC_IMEM_DEPTH];
  logic [15:0] pc;
  logic        haltFlag;

  // Program load port, writes land at the edge
  always_ff @(posedge clk) begin
    if (progLoad.valid) begin
      imem[progLoad.addr] <= progLoad.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc       <= '0;
      haltFlag <= 1'b0;
    end else begin
      if (halted) begin
        haltFlag <= 1'b1;
      end
      // PC stays on the HALT word once it has been seen
      if (!halt) begin
        pc <= redirect ? target : pcPlusOne;
      end
    end
  end

  assign pcPlusOne = pc + 16'd1;

  // Only the low PC bits index the memory
  assign instr = imem[pc[`PROC_IMEM_AW-1:0]];

  assign halt = haltFlag || halted;

endmodule

// File: source/proc_pkg.sv
package procPkg;

  // Five-bit major opcode in bits [15:11]
  typedef enum logic [4:0] {
    opHalt  = 5'b00000,
    opNop   = 5'b00001,
    opJ     = 5'b00100,
    opAddi  = 5'b01000,
    opSubi  = 5'b01001,
    opXori  = 5'b01010,
    opAndni = 5'b01011,
    opBeqz  = 5'b01100,
    opBnez  = 5'b01101,
    opSt    = 5'b10000,
    opLd    = 5'b10001,
    opAlu   = 5'b11011
  } opcodeT;

  // Low two opcode bits of the I-format ALU group line up with this
  typedef enum logic [1:0] {
    aluAdd  = 2'b00,
    aluSub  = 2'b01,
    aluXor  = 2'b10,
    aluAndn = 2'b11
  } aluOpT;

  typedef struct packed {
    opcodeT     opcode;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] rd;
    logic [1:0] funct;
  } rFormatT;

  // rd sits where the R-format keeps rt
  typedef struct packed {
    opcodeT     opcode;
    logic [2:0] rs;
    logic [2:0] rd;
    logic [4:0] imm5;
  } iFormatT;

  typedef struct packed {
    opcodeT      opcode;
    logic [10:0] disp11;
  } jFormatT;

  // One fetched word, read in whichever format the opcode calls for
  typedef union packed {
    rFormatT r;
    iFormatT i;
    jFormatT j;
  } instrT;

  typedef struct packed {
    logic  regWrite;
    logic  aluSrc;
    logic  memRead;
    logic  memWrite;
    logic  memToReg;
    logic  branch;
    logic  branchOnZero;
    logic  jump;
    logic  halt;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    ctrlT        ctrl;
    logic [15:0] rsData;
    logic [15:0] rtData;
    logic [15:0] immediate;
    logic [2:0]  writeReg;
    logic [15:0] pcPlusOne;
  } decodedT;

  typedef struct packed {
    ctrlT        ctrl;
    logic [15:0] aluResult;
    logic [15:0] storeData;
    logic [2:0]  writeReg;
  } execT;

  typedef struct packed {
    logic        valid;
    logic [2:0]  regNum;
    logic [15:0] data;
  } wbEventT;

  typedef struct packed {
    logic        valid;
    logic [7:0]  addr;
    logic [15:0] data;
  } progLoadT;

endpackage

// File: source/proc_settings.svh
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// Instruction memory, one 16-bit word per entry
`define PROC_IMEM_DEPTH 256
`define PROC_IMEM_AW    8

// Data memory, word addressed
`define PROC_DMEM_DEPTH 256
`define PROC_DMEM_AW    8

// General purpose registers r0 to r7
// r0 is an ordinary register here and not hardwired to zero
`define PROC_NUM_REGS   8

`endif
